//--- hdl/axil_bridge_pkg.sv
// Address and data widths, AXI response codes, and the stream and AXI-Lite bus structs
`default_nettype none

package axil_bridge_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;

    // Only the two codes the register bank can produce
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_t;

    // Stream beats
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } write_cmd_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
    } read_req_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        resp_t                 resp;
    } read_rsp_t;

    // Everything the AXI-Lite master drives
    typedef struct packed {
        logic [addr_width-1:0] awaddr;
        logic                  awvalid;
        logic [data_width-1:0] wdata;
        logic                  wvalid;
        logic                  bready;
        logic [addr_width-1:0] araddr;
        logic                  arvalid;
        logic                  rready;
    } axil_m2s_t;

    // Everything the AXI-Lite slave drives
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        resp_t                 bresp;
        logic                  bvalid;
        logic                  arready;
        logic [data_width-1:0] rdata;
        resp_t                 rresp;
        logic                  rvalid;
    } axil_s2m_t;

endpackage

`default_nettype wire

//--- hdl/axis_to_axil.sv
// Stream-to-AXI-Lite bridge with separate write and read engines and a read-after-write hold
`timescale 1ns/10ps
`default_nettype none

module axis_to_axil (
    input  logic                       clock,
    input  logic                       reset,
    input  axil_bridge_pkg::write_cmd_t write_cmd,
    input  logic                       write_valid,
    output logic                       write_ready,
    input  axil_bridge_pkg::read_req_t read_req,
    input  logic                       read_req_valid,
    output logic                       read_req_ready,
    output axil_bridge_pkg::read_rsp_t read_rsp,
    output logic                       read_rsp_valid,
    input  logic                       read_rsp_ready,
    output axil_bridge_pkg::axil_m2s_t axil_out,
    input  axil_bridge_pkg::axil_s2m_t axil_in
);

    import axil_bridge_pkg::*;

    typedef enum logic [1:0] {
        write_idle,
        write_send,
        write_response
    } write_state_t;

    typedef enum logic [1:0] {
        read_idle,
        read_address,
        read_wait_data,
        read_respond
    } read_state_t;

    write_state_t write_state;
    write_cmd_t   write_beat;
    logic         aw_pending;
    logic         w_pending;
    logic         aw_accepted;
    logic         w_accepted;

    read_state_t  read_state;
    read_req_t    read_beat;

    // Write engine

    assign write_ready = (write_state == write_idle);

    // A channel is done on the edge where its valid meets its ready
    assign aw_accepted = aw_pending && axil_in.awready;
    assign w_accepted  = w_pending && axil_in.wready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_state <= write_idle;
            aw_pending  <= 1'b0;
            w_pending   <= 1'b0;
        end else begin
            case (write_state)
                write_idle: begin
                    if (write_valid) begin
                        aw_pending  <= 1'b1;
                        w_pending   <= 1'b1;
                        write_state <= write_send;
                    end
                end
                write_send: begin
                    if (aw_accepted) begin
                        aw_pending <= 1'b0;
                    end
                    if (w_accepted) begin
                        w_pending <= 1'b0;
                    end
                    // AW and W may finish in either order, or together
                    if ((aw_accepted || !aw_pending) && (w_accepted || !w_pending)) begin
                        write_state <= write_response;
                    end
                end
                write_response: begin
                    if (axil_in.bvalid) begin
                        write_state <= write_idle;
                    end
                end
                default: begin
                    write_state <= write_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (write_valid && write_ready) begin
            write_beat <= write_cmd;
        end
    end

    // Read engine

    // Reads wait for any write in flight so they always observe it
    assign read_req_ready = (read_state == read_idle) && (write_state == write_idle);
    assign read_rsp_valid = (read_state == read_respond);

    always_ff @(posedge clock) begin
        if (!reset) begin
            read_state <= read_idle;
        end else begin
            case (read_state)
                read_idle: begin
                    if (read_req_valid && read_req_ready) begin
                        read_state <= read_address;
                    end
                end
                read_address: begin
                    if (axil_in.arready) begin
                        read_state <= read_wait_data;
                    end
                end
                read_wait_data: begin
                    if (axil_in.rvalid) begin
                        read_state <= read_respond;
                    end
                end
                read_respond: begin
                    if (read_rsp_ready) begin
                        read_state <= read_idle;
                    end
                end
                default: begin
                    read_state <= read_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (read_req_valid && read_req_ready) begin
            read_beat <= read_req;
        end
        // Result is held here until the response stream takes it
        if ((read_state == read_wait_data) && axil_in.rvalid) begin
            read_rsp.data <= axil_in.rdata;
            read_rsp.resp <= axil_in.rresp;
        end
    end

    // Master side of the bus

    always_comb begin
        axil_out.awaddr  = write_beat.addr;
        axil_out.awvalid = aw_pending;
        axil_out.wdata   = write_beat.data;
        axil_out.wvalid  = w_pending;
        axil_out.bready  = (write_state == write_response);
        axil_out.araddr  = read_beat.addr;
        axil_out.arvalid = (read_state == read_address);
        axil_out.rready  = (read_state == read_wait_data);
    end

endmodule

`default_nettype wire

//--- hdl/axil_register_bank.sv
// AXI-Lite slave with a bank of 32-bit registers and address range checking
`timescale 1ns/10ps
`default_nettype none

module axil_register_bank #(
    parameter int register_count = 8
) (
    input  logic                       clock,
    input  logic                       reset,
    input  axil_bridge_pkg::axil_m2s_t axil_in,
    output axil_bridge_pkg::axil_s2m_t axil_out
);

    import axil_bridge_pkg::*;

    localparam int index_width = $clog2(register_count);

    logic [data_width-1:0] registers [register_count];

    logic                  aw_full;
    logic                  w_full;
    logic [addr_width-1:0] write_address;
    logic [data_width-1:0] write_data;
    logic                  bvalid;
    resp_t                 bresp;
    logic                  rvalid;
    logic [data_width-1:0] rdata;
    resp_t                 rresp;

    logic                  awready;
    logic                  wready;
    logic                  arready;
    logic                  write_fire;
    logic                  read_fire;

    // Word index is taken from bit 2 upwards
    function automatic logic in_range(input logic [addr_width-1:0] address);
        return address[addr_width-1:2] < (addr_width - 2)'(register_count);
    endfunction

    function automatic logic [index_width-1:0] word_index(
        input logic [addr_width-1:0] address
    );
        return address[index_width+1:2];
    endfunction

    // Each channel takes one item and then stalls until B has gone out
    assign awready    = !bvalid && !aw_full;
    assign wready     = !bvalid && !w_full;
    assign arready    = !rvalid;
    assign write_fire = aw_full && w_full;
    assign read_fire  = axil_in.arvalid && arready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            for (int i = 0; i < register_count; i++) begin
                registers[i] <= '0;
            end
        end else begin
            if (axil_in.awvalid && awready) begin
                aw_full <= 1'b1;
            end
            if (axil_in.wvalid && wready) begin
                w_full <= 1'b1;
            end

            if (write_fire) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
                bvalid  <= 1'b1;
                // Out-of-range writes are dropped and only the response reports them
                if (in_range(write_address)) begin
                    registers[word_index(write_address)] <= write_data;
                end
            end else if (bvalid && axil_in.bready) begin
                bvalid <= 1'b0;
            end

            if (read_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && axil_in.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (axil_in.awvalid && awready) begin
            write_address <= axil_in.awaddr;
        end
        if (axil_in.wvalid && wready) begin
            write_data <= axil_in.wdata;
        end
        if (write_fire) begin
            bresp <= in_range(write_address) ? resp_okay : resp_slverr;
        end
        if (read_fire) begin
            if (in_range(axil_in.araddr)) begin
                rdata <= registers[word_index(axil_in.araddr)];
                rresp <= resp_okay;
            end else begin
                rdata <= '0;
                rresp <= resp_slverr;
            end
        end
    end

    always_comb begin
        axil_out.awready = awready;
        axil_out.wready  = wready;
        axil_out.bresp   = bresp;
        axil_out.bvalid  = bvalid;
        axil_out.arready = arready;
        axil_out.rdata   = rdata;
        axil_out.rresp   = rresp;
        axil_out.rvalid  = rvalid;
    end

endmodule

`default_nettype wire

//--- hdl/axil_bridge_top.sv
// Top level joining the stream bridge to the AXI-Lite register bank
`timescale 1ns/10ps
`default_nettype none

module axil_bridge_top #(
    parameter int register_count = 8
) (
    input  logic                       clock,
    input  logic                       reset,
    input  axil_bridge_pkg::write_cmd_t write_cmd,
    input  logic                       write_valid,
    output logic                       write_ready,
    input  axil_bridge_pkg::read_req_t read_req,
    input  logic                       read_req_valid,
    output logic                       read_req_ready,
    output axil_bridge_pkg::read_rsp_t read_rsp,
    output logic                       read_rsp_valid,
    input  logic                       read_rsp_ready
);

    import axil_bridge_pkg::*;

    // Internal AXI-Lite bus, one struct per direction
    axil_m2s_t axil_m2s;
    axil_s2m_t axil_s2m;

    axis_to_axil bridge_i (
        .clock          (clock),
        .reset          (reset),
        .write_cmd      (write_cmd),
        .write_valid    (write_valid),
        .write_ready    (write_ready),
        .read_req       (read_req),
        .read_req_valid (read_req_valid),
        .read_req_ready (read_req_ready),
        .read_rsp       (read_rsp),
        .read_rsp_valid (read_rsp_valid),
        .read_rsp_ready (read_rsp_ready),
        .axil_out       (axil_m2s),
        .axil_in        (axil_s2m)
    );

    axil_register_bank #(
        .register_count (register_count)
    ) bank_i (
        .clock    (clock),
        .reset    (reset),
        .axil_in  (axil_m2s),
        .axil_out (axil_s2m)
    );

endmodule

`default_nettype wire

//--- verif/clock_gen.sv
// Testbench clock and active-low reset generator
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    localparam int half_period = 4;
    localparam int reset_cycles = 4;

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    // Release lands just after an edge, like the rest of the stimulus
    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/axil_bridge_props.sv
// Handshake stability and read-after-write hold assertions, bound to the bridge top level
`timescale 1ns/10ps
`default_nettype none

module axil_bridge_props (
    input logic                       clock,
    input logic                       reset,
    input axil_bridge_pkg::axil_m2s_t axil_m2s,
    input axil_bridge_pkg::axil_s2m_t axil_s2m,
    input axil_bridge_pkg::read_rsp_t read_rsp,
    input logic                       read_rsp_valid,
    input logic                       read_rsp_ready,
    input logic                       write_ready,
    input logic                       read_req_ready
);

    aw_held: assert property (@(posedge clock) disable iff (!reset)
        axil_m2s.awvalid && !axil_s2m.awready |=> axil_m2s.awvalid && $stable(axil_m2s.awaddr))
        else $error("AW valid or address changed before awready");

    w_held: assert property (@(posedge clock) disable iff (!reset)
        axil_m2s.wvalid && !axil_s2m.wready |=> axil_m2s.wvalid && $stable(axil_m2s.wdata))
        else $error("W valid or data changed before wready");

    ar_held: assert property (@(posedge clock) disable iff (!reset)
        axil_m2s.arvalid && !axil_s2m.arready |=> axil_m2s.arvalid && $stable(axil_m2s.araddr))
        else $error("AR valid or address changed before arready");

    rsp_held: assert property (@(posedge clock) disable iff (!reset)
        read_rsp_valid && !read_rsp_ready |=> read_rsp_valid && $stable(read_rsp))
        else $error("Read response valid or payload changed before it was taken");

    // No read may start while a write is still in flight
    read_after_write: assert property (@(posedge clock) disable iff (!reset)
        read_req_ready |-> write_ready)
        else $error("read_req_ready high while the write engine is busy");

endmodule

`default_nettype wire

//--- verif/axil_bridge_tb.sv
// Testbench top with golden-file stream stimulus and in-order read response checking
`timescale 1ns/10ps
`default_nettype none

module axil_bridge_tb;

    import axil_bridge_pkg::*;

    localparam int    register_count = 8;
    localparam int    timeout_cycles = 200;
    localparam string golden_path = "verif/axil_bridge_golden.txt";

    logic       clock;
    logic       reset;
    write_cmd_t write_cmd;
    logic       write_valid;
    logic       write_ready;
    read_req_t  read_req;
    logic       read_req_valid;
    logic       read_req_ready;
    read_rsp_t  read_rsp;
    logic       read_rsp_valid;
    logic       read_rsp_ready;

    integer seed = 32'h1518;

    // Reads still owed a response, oldest first
    read_rsp_t             expected_rsp [$];
    logic [addr_width-1:0] expected_addr [$];
    int                    responses_checked = 0;

    clock_gen clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    axil_bridge_top #(
        .register_count (register_count)
    ) dut_i (
        .clock          (clock),
        .reset          (reset),
        .write_cmd      (write_cmd),
        .write_valid    (write_valid),
        .write_ready    (write_ready),
        .read_req       (read_req),
        .read_req_valid (read_req_valid),
        .read_req_ready (read_req_ready),
        .read_rsp       (read_rsp),
        .read_rsp_valid (read_rsp_valid),
        .read_rsp_ready (read_rsp_ready)
    );

    bind axil_bridge_top axil_bridge_props props_i (
        .clock          (clock),
        .reset          (reset),
        .axil_m2s       (axil_m2s),
        .axil_s2m       (axil_s2m),
        .read_rsp       (read_rsp),
        .read_rsp_valid (read_rsp_valid),
        .read_rsp_ready (read_rsp_ready),
        .write_ready    (write_ready),
        .read_req_ready (read_req_ready)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            #1;
        end
    endtask

    // Both send tasks start and end 1 ns after a rising edge
    task automatic send_write(input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] data);
        int waited;
        waited = 0;
        write_cmd.addr = addr;
        write_cmd.data = data;
        write_valid    = 1'b1;
        @(negedge clock);
        while (!write_ready) begin
            if (waited == timeout_cycles) begin
                fail_run("Timed out waiting for write_ready");
            end
            waited++;
            @(negedge clock);
        end
        @(posedge clock);
        #1;
        write_valid = 1'b0;
    endtask

    task automatic send_read(input logic [addr_width-1:0] addr, input read_rsp_t expected);
        int waited;
        waited = 0;
        read_req.addr  = addr;
        read_req_valid = 1'b1;
        @(negedge clock);
        while (!read_req_ready) begin
            if (waited == timeout_cycles) begin
                fail_run("Timed out waiting for read_req_ready");
            end
            waited++;
            @(negedge clock);
        end
        expected_rsp.push_back(expected);
        expected_addr.push_back(addr);
        @(posedge clock);
        #1;
        read_req_valid = 1'b0;
    endtask

    task automatic check_read_rsp(input read_rsp_t actual, input read_rsp_t expected,
                                  input logic [addr_width-1:0] addr);
        logic failed;
        failed = 1'b0;
        if (actual.data !== expected.data) begin
            $display("Mismatch read_rsp.data at address 0x%h: expected 0x%h, got 0x%h",
                     addr, expected.data, actual.data);
            failed = 1'b1;
        end
        if (actual.resp !== expected.resp) begin
            $display("Mismatch read_rsp.resp at address 0x%h: expected 0x%h, got 0x%h",
                     addr, expected.resp, actual.resp);
            failed = 1'b1;
        end
        if (failed) begin
            fail_run("Read response differs from the golden file");
        end
    endtask

    // Random back-pressure on the response stream; each response must match the oldest read
    initial begin : response_checker
        logic                  next_ready;
        int                    waited;
        read_rsp_t             expected;
        logic [addr_width-1:0] addr;
        read_rsp_ready = 1'b0;
        next_ready     = 1'b0;
        waited         = 0;
        forever begin
            @(posedge clock);
            #1;
            read_rsp_ready = next_ready;
            @(negedge clock);
            if (read_rsp_valid && read_rsp_ready) begin
                if (expected_rsp.size() == 0) begin
                    fail_run("A read response arrived with no read outstanding");
                end else begin
                    expected = expected_rsp.pop_front();
                    addr     = expected_addr.pop_front();
                    check_read_rsp(read_rsp, expected, addr);
                    responses_checked++;
                    waited = 0;
                end
            end else if (expected_rsp.size() != 0) begin
                waited++;
                if (waited > timeout_cycles) begin
                    fail_run("Timed out waiting for a read response");
                end
            end
            next_ready = ($random(seed) & 3) != 0;
        end
    end

    initial begin : stimulus
        int                    fd;
        string                 line;
        int                    line_number;
        int                    count;
        int                    waited;
        int                    read_count;
        logic [7:0]            op;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
        logic [1:0]            resp_field;
        logic                  previous_write;
        read_rsp_t             expected;
        write_cmd      = '0;
        write_valid    = 1'b0;
        read_req       = '0;
        read_req_valid = 1'b0;
        line_number    = 0;
        read_count     = 0;
        previous_write = 1'b0;
        waited         = 0;

        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            fail_run("Could not open the golden file");
        end

        @(negedge clock);
        while (!reset) begin
            if (waited == timeout_cycles) begin
                fail_run("Timed out waiting for reset to be released");
            end
            waited++;
            @(negedge clock);
        end
        @(posedge clock);
        #1;

        while ($fgets(line, fd) != 0) begin
            line_number++;
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            count = $sscanf(line, "%c %h %h %h", op, addr, data, resp_field);
            if (count != 4) begin
                fail_run($sformatf("Golden file line %0d could not be parsed", line_number));
            end
            if (op == "W") begin
                idle_gap($unsigned($random(seed)) % 3);
                send_write(addr, data);
                previous_write = 1'b1;
            end else if (op == "R") begin
                // A read right behind a write runs into the read-after-write hold
                if (!previous_write) begin
                    idle_gap($unsigned($random(seed)) % 3);
                end
                expected.data = data;
                expected.resp = resp_t'(resp_field);
                send_read(addr, expected);
                read_count++;
                previous_write = 1'b0;
            end else begin
                fail_run($sformatf("Golden file line %0d has an unknown operation", line_number));
            end
        end
        $fclose(fd);

        waited = 0;
        while (expected_rsp.size() != 0) begin
            if (waited == timeout_cycles) begin
                fail_run("Timed out waiting for the last read responses");
            end
            waited++;
            @(negedge clock);
        end

        if (read_count == 0) begin
            fail_run("The golden file held no reads");
        end

        // The last response leaves on the next edge and the bridge must then sit idle
        @(posedge clock);
        #1;
        @(negedge clock);
        if (!read_rsp_valid && write_ready && read_req_ready) begin
            $display("Checked %0d read responses", responses_checked);
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("The bridge did not return to idle after the last read response");
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- verif/axil_bridge_golden.txt
# Columns: op (W or R), address, data, response code; all fields hex
# W: data is written, response unused. R: expected data and response (0 okay, 2 slverr)
R 00000000 00000000 0
R 00000004 00000000 0
R 00000010 00000000 0
R 0000001c 00000000 0
W 00000008 cafe0001 0
R 00000008 cafe0001 0
W 0000000c 12345678 0
R 0000000c 12345678 0
W 00000008 0badf00d 0
R 00000008 0badf00d 0
R 0000000e 12345678 0
R 00000020 00000000 2
R 00000023 00000000 2
R 00000100 00000000 2
R 80000000 00000000 2
W 00000020 deadbeef 0
W 00000024 deadbeef 0
W 40000008 deadbeef 0
R 00000000 00000000 0
R 00000004 00000000 0
R 00000008 0badf00d 0
R 0000000c 12345678 0
R 00000010 00000000 0
R 00000014 00000000 0
R 00000018 00000000 0
R 0000001c 00000000 0
W 00000000 a0a0a0a0 0
W 00000004 b1b1b1b1 0
W 00000008 c2c2c2c2 0
W 0000000c d3d3d3d3 0
W 00000010 e4e4e4e4 0
W 00000014 f5f5f5f5 0
W 00000018 06060606 0
W 0000001c 17171717 0
W 00000004 11110004 0
W 00000018 22220018 0
R 00000000 a0a0a0a0 0
R 00000004 11110004 0
R 00000008 c2c2c2c2 0
R 0000000c d3d3d3d3 0
R 00000010 e4e4e4e4 0
R 00000014 f5f5f5f5 0
R 00000018 22220018 0
R 0000001c 17171717 0

//--- sources.f
hdl/axil_bridge_pkg.sv
hdl/axis_to_axil.sv
hdl/axil_register_bank.sv
hdl/axil_bridge_top.sv
verif/clock_gen.sv
verif/axil_bridge_props.sv
verif/axil_bridge_tb.sv

//--- Makefile
# Verilator build and run of the AXI-Lite bridge testbench
TOP := axil_bridge_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
